/* Makefile */
# Verilator simulation of the MMIO client testbench

VERILATOR ?= verilator
TOP       ?= mmioClientTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+test
rtl/mmioPkg.sv
rtl/shellPkg.sv
rtl/mmioPageRam.sv
rtl/mmioRegFile.sv
rtl/mmioBusDecode.sv
rtl/mmioClient.sv
test/mmioClientTb.sv

/* rtl/mmioBusDecode.sv */
// MMIO bus decoder
// Splits each access between the register file (address bit 7 low)
// and the page RAM (bit 7 high). Both return their byte one cycle
// later; the decoder remembers which space was read and raises rdValid
// for that one cycle.

`timescale 1ns/1ns

module mmioBusDecode (
  input  logic              shlClk,
  input  logic              rstN,
  input  mmioPkg::mmioReq_t req,
  output mmioPkg::mmioReq_t regReq,
  output mmioPkg::mmioReq_t ramReq,
  input  mmioPkg::data_t    regRdData,
  input  mmioPkg::data_t    ramRdData,
  output mmioPkg::data_t    rdData,
  output logic              rdValid
);

  logic ramSpace;      // Window bit of the current access
  logic ramSpaceQ;     // Window of the pending read
  logic rdValidQ;

  assign ramSpace = req.addr[mmioPkg::addrWidth-1];

  // ----------------------------------------
  // Request split
  // ----------------------------------------
  always_comb
  begin
    regReq    = req;
    regReq.cs = req.cs && !ramSpace;
    ramReq    = req;
    ramReq.cs = req.cs && ramSpace;
  end

  // ----------------------------------------
  // Read return
  // ----------------------------------------
  always_ff @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
    begin
      ramSpaceQ <= 1'b0;
      rdValidQ  <= 1'b0;
    end
    else
    begin
      rdValidQ <= req.cs && !req.we;
      if (req.cs && !req.we)
        ramSpaceQ <= ramSpace;   // Hold until next read
    end
  end

  assign rdData  = ramSpaceQ ? ramRdData : regRdData;
  assign rdValid = rdValidQ;

endmodule

/* rtl/mmioClient.sv */
// MMIO client, top level
// Byte wide chip-select bus from the management processor into a
// 128 byte shell register file and a paged RAM window above it.
// All on the shell clock; reads return one cycle after the access.

`timescale 1ns/1ns

module mmioClient #(
  parameter mmioPkg::data_t emifId    = 8'h3C,
  parameter mmioPkg::data_t topId     = 8'h81,
  parameter int             pageCount = 16
) (
  input  logic                 shlClk,
  input  logic                 rstN,
  input  mmioPkg::mmioReq_t    req,
  input  shellPkg::shellStat_t stat,
  output mmioPkg::data_t       rdData,
  output logic                 rdValid,
  output shellPkg::eth0Ctrl_t  eth0Ctrl,
  output shellPkg::ntsCfg_t    ntsCfg,
  output shellPkg::roleCtrl_t  roleCtrl
);

  mmioPkg::mmioReq_t regReq;     // Lower window
  mmioPkg::mmioReq_t ramReq;     // Upper window
  mmioPkg::data_t    regRdData;
  mmioPkg::data_t    ramRdData;
  mmioPkg::data_t    pageSel;

  // ----------------------------------------
  // Decode, register file, page RAM
  // ----------------------------------------
  mmioBusDecode busDecode_i (
    .shlClk, .rstN, .req, .regReq, .ramReq,
    .regRdData, .ramRdData, .rdData, .rdValid
  );

  mmioRegFile #(.emifId(emifId), .topId(topId)) regFile_i (
    .shlClk, .rstN, .regReq, .stat, .regRdData,
    .pageSel, .eth0Ctrl, .ntsCfg, .roleCtrl
  );

  mmioPageRam #(.pageCount(pageCount)) pageRam_i (
    .shlClk,
    .ramReq,
    .pageSel,                    // From the page select byte
    .ramRdData
  );

endmodule

/* rtl/mmioPageRam.sv */
// MMIO page RAM
// Byte RAM behind the upper 128 byte window. The page select byte picks
// which 128 byte page of the RAM is visible. Read byte is registered.

`timescale 1ns/1ns

module mmioPageRam #(
  parameter int pageCount = 16    // Power of two, at least 2
) (
  input  logic              shlClk,
  input  mmioPkg::mmioReq_t ramReq,
  input  mmioPkg::data_t    pageSel,
  output mmioPkg::data_t    ramRdData
);

  localparam int pageBits  = $clog2(pageCount);
  localparam int ramDepth  = pageCount * mmioPkg::pageSize;
  localparam int ramAWidth = pageBits + mmioPkg::regAddrWidth;

  mmioPkg::data_t       mem [ramDepth];
  logic [ramAWidth-1:0] ramAddr;

  // Page in the upper bits, window offset below
  assign ramAddr = {pageSel[pageBits-1:0], ramReq.addr[mmioPkg::regAddrWidth-1:0]};

  // ----------------------------------------
  // Single port access
  // ----------------------------------------
  always_ff @(posedge shlClk)
  begin
    if (ramReq.cs && ramReq.we)
      mem[ramAddr] <= ramReq.wrData;
  end

  always_ff @(posedge shlClk)
  begin
    if (ramReq.cs && !ramReq.we)
      ramRdData <= mem[ramAddr];     // Latency 1
  end

  // Register file must not select a page beyond the RAM
  pageInRange: assert property (@(posedge shlClk)
    ramReq.cs |-> pageSel < pageCount)
    else $error("Page select %0d beyond page count", pageSel);

endmodule

/* rtl/mmioPkg.sv */
// MMIO bus package
// Bus widths, the request struct, the register map of the lower window
// and the reset values of the writable bytes

package mmioPkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int dataWidth    = 8;
  localparam int addrWidth    = 8;
  localparam int regAddrWidth = 7;                    // Offset inside one window
  localparam int pageSize     = 2 ** regAddrWidth;    // Bytes per window

  typedef logic [addrWidth-1:0]    addr_t;
  typedef logic [dataWidth-1:0]    data_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;

  // One bus access, sampled on every rising edge
  typedef struct packed {
    logic  cs;      // Access strobe
    logic  we;      // Write when high, read otherwise
    addr_t addr;    // Bit 7 picks the window
    data_t wrData;
  } mmioReq_t;

  // ----------------------------------------
  // Register offsets
  // ----------------------------------------
  localparam regAddr_t cfgEmifId   = 7'h00;
  localparam regAddr_t cfgEmifVer  = 7'h01;
  localparam regAddr_t cfgEmifRev  = 7'h02;
  localparam regAddr_t cfgReserved = 7'h03;
  localparam regAddr_t cfgTopId    = 7'h04;
  localparam regAddr_t cfgTopYear  = 7'h05;
  localparam regAddr_t cfgTopMonth = 7'h06;
  localparam regAddr_t cfgTopDay   = 7'h07;
  localparam regAddr_t phyStat     = 7'h10;
  localparam regAddr_t phyEth0     = 7'h11;   // 3 bytes
  localparam regAddr_t ly2Mac      = 7'h22;   // 6 bytes, LSB first
  localparam regAddr_t ly3Ip       = 7'h34;   // 4 bytes
  localparam regAddr_t ly3Snm      = 7'h38;
  localparam regAddr_t ly3Gtw      = 7'h3C;
  localparam regAddr_t roleIn      = 7'h40;   // Read only, 2 bytes
  localparam regAddr_t roleOut     = 7'h42;   // 2 bytes
  localparam regAddr_t diagScratch = 7'h70;
  localparam regAddr_t diagCtrl1   = 7'h74;   // Loopback and swap enables
  localparam regAddr_t diagCtrl2   = 7'h76;   // UDP/TCP echo and capture
  localparam regAddr_t pageSel     = 7'h7F;

  // ----------------------------------------
  // Reset values
  // ----------------------------------------
  localparam data_t emifVerRst  = 8'h01;
  localparam data_t emifRevRst  = 8'h00;
  localparam data_t reservedRst = 8'h33;
  localparam logic [2:0][7:0] eth0Rst    = {8'h05, 8'h05, 8'h41};
  localparam logic [3:0][7:0] snmRst     = {8'h00, 8'h00, 8'hFF, 8'hFF};  // 255.255.0.0
  localparam logic [3:0][7:0] gtwRst     = {8'hFE, 8'h00, 8'h0C, 8'h0A};  // 10.12.0.254
  localparam logic [3:0][7:0] scratchRst = {8'hEF, 8'hBE, 8'hAD, 8'hDE};

  // Bytes that hold storage
  function automatic logic isWritable(regAddr_t off);
    return (off >= phyEth0 && off <= phyEth0 + 2) ||
           (off >= ly2Mac && off <= ly2Mac + 5) ||
           (off >= ly3Ip && off <= ly3Gtw + 3) ||    // IP, subnet, gateway
           (off == roleOut) || (off == roleOut + 1) ||
           (off >= diagScratch && off <= diagCtrl1) ||
           (off == diagCtrl2) || (off == pageSel);
  endfunction

  function automatic data_t rstVal(regAddr_t off);
    data_t val;
    val = '0;
    if (off >= phyEth0 && off <= phyEth0 + 2) val = eth0Rst[off - phyEth0];
    if (off >= ly3Snm && off <= ly3Snm + 3) val = snmRst[off - ly3Snm];
    if (off >= ly3Gtw && off <= ly3Gtw + 3) val = gtwRst[off - ly3Gtw];
    if (off >= diagScratch && off <= diagScratch + 3) val = scratchRst[off - diagScratch];
    return val;
  endfunction

endpackage

/* rtl/mmioRegFile.sv */
// MMIO register file
// 128 byte control and status space of the shell. Writable bytes hold
// storage with their reset values; identity, build date, PHY status and
// the inbound role word are overlaid on read. Read byte is registered,
// latency 1. Stored bytes are packed into the shell control structs.

`timescale 1ns/1ns

module mmioRegFile #(
  parameter mmioPkg::data_t emifId = 8'h3C,
  parameter mmioPkg::data_t topId  = 8'h81
) (
  input  logic                 shlClk,
  input  logic                 rstN,
  input  mmioPkg::mmioReq_t    regReq,
  input  shellPkg::shellStat_t stat,
  output mmioPkg::data_t       regRdData,
  output mmioPkg::data_t       pageSel,
  output shellPkg::eth0Ctrl_t  eth0Ctrl,
  output shellPkg::ntsCfg_t    ntsCfg,
  output shellPkg::roleCtrl_t  roleCtrl
);

  mmioPkg::data_t    regQ [mmioPkg::pageSize];   // Zero where nothing is stored
  mmioPkg::regAddr_t offset;
  mmioPkg::data_t    rdByte;
  logic              wrEn;

  assign offset = regReq.addr[mmioPkg::regAddrWidth-1:0];  // Window bit already decoded
  assign wrEn   = regReq.cs && regReq.we;

  // ----------------------------------------
  // Storage, writable bytes only
  // ----------------------------------------
  for (genvar i = 0; i < mmioPkg::pageSize; i++)
  begin : genByte
    if (mmioPkg::isWritable(mmioPkg::regAddr_t'(i)))
    begin : genRw
      mmioPkg::data_t byteQ;

      always_ff @(posedge shlClk or negedge rstN)
      begin
        if (!rstN)
          byteQ <= mmioPkg::rstVal(mmioPkg::regAddr_t'(i));
        else if (wrEn && offset == mmioPkg::regAddr_t'(i))
          byteQ <= regReq.wrData;
      end

      assign regQ[i] = byteQ;
    end
    else
    begin : genRo
      assign regQ[i] = '0;     // Read only or reserved
    end
  end

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_comb
  begin
    rdByte = regQ[offset];
    case (offset)
      mmioPkg::cfgEmifId:   rdByte = emifId;
      mmioPkg::cfgEmifVer:  rdByte = mmioPkg::emifVerRst;
      mmioPkg::cfgEmifRev:  rdByte = mmioPkg::emifRevRst;
      mmioPkg::cfgReserved: rdByte = mmioPkg::reservedRst;
      mmioPkg::cfgTopId:    rdByte = topId;
      mmioPkg::cfgTopYear:  rdByte = {2'b00, stat.timestamp[22:17]};
      mmioPkg::cfgTopMonth: rdByte = {4'b0000, stat.timestamp[26:23]};
      mmioPkg::cfgTopDay:   rdByte = {3'b000, stat.timestamp[31:27]};
      mmioPkg::phyStat:     rdByte = {4'b0000, stat.eth0QpllLock, stat.eth0CoreReady,
                                      stat.mc1InitCalComplete, stat.mc0InitCalComplete};
      mmioPkg::roleIn:      rdByte = stat.roleReg[7:0];     // Little endian
      mmioPkg::roleIn + 1:  rdByte = stat.roleReg[15:8];
      default: ;                                            // Stored byte or zero
    endcase
  end

  always_ff @(posedge shlClk)
  begin
    if (regReq.cs && !regReq.we)
      regRdData <= rdByte;
  end

  // ----------------------------------------
  // Control outputs
  // ----------------------------------------
  assign pageSel = regQ[mmioPkg::pageSel];

  always_comb
  begin
    eth0Ctrl.rxEqualizerMode = regQ[mmioPkg::phyEth0][0];
    eth0Ctrl.txDriverSwing   = regQ[mmioPkg::phyEth0][7:4];
    eth0Ctrl.txPreCursor     = regQ[mmioPkg::phyEth0 + 1][4:0];
    eth0Ctrl.txPostCursor    = regQ[mmioPkg::phyEth0 + 2][4:0];
    eth0Ctrl.pcsLoopbackEn   = regQ[mmioPkg::diagCtrl1][0];
    eth0Ctrl.macLoopbackEn   = regQ[mmioPkg::diagCtrl1][1];
    eth0Ctrl.macAddrSwapEn   = regQ[mmioPkg::diagCtrl1][2];

    // Lowest offset is least significant byte
    for (int b = 0; b < 6; b++)
      ntsCfg.macAddress[8*b +: 8] = regQ[mmioPkg::ly2Mac + b];
    for (int b = 0; b < 4; b++)
    begin
      ntsCfg.ipAddress[8*b +: 8]   = regQ[mmioPkg::ly3Ip + b];
      ntsCfg.subNetMask[8*b +: 8]  = regQ[mmioPkg::ly3Snm + b];
      ntsCfg.gatewayAddr[8*b +: 8] = regQ[mmioPkg::ly3Gtw + b];
    end

    roleCtrl.udpEchoCtrl  = regQ[mmioPkg::diagCtrl2][1:0];
    roleCtrl.udpPostPktEn = regQ[mmioPkg::diagCtrl2][2];
    roleCtrl.udpCaptPktEn = regQ[mmioPkg::diagCtrl2][3];
    roleCtrl.tcpEchoCtrl  = regQ[mmioPkg::diagCtrl2][5:4];
    roleCtrl.tcpPostPktEn = regQ[mmioPkg::diagCtrl2][6];
    roleCtrl.tcpCaptPktEn = regQ[mmioPkg::diagCtrl2][7];
    roleCtrl.roleReg      = {regQ[mmioPkg::roleOut + 1], regQ[mmioPkg::roleOut]};
  end

  // Writes to read-only or reserved offsets touch no stored byte
  roWriteNoEffect: assert property (@(posedge shlClk) disable iff (!rstN)
    wrEn && !mmioPkg::isWritable(offset)
    |=> $stable({pageSel, eth0Ctrl, ntsCfg, roleCtrl}))
    else $error("Write to a read-only offset changed a control output");

endmodule

/* rtl/shellPkg.sv */
// Shell side package
// Control structs driven by the MMIO register file and the status
// struct it samples from the shell

package shellPkg;

  localparam int macWidth       = 48;
  localparam int ipWidth        = 32;
  localparam int roleRegWidth   = 16;
  localparam int timestampWidth = 32;

  // ----------------------------------------
  // Control outputs
  // ----------------------------------------
  // ETH0 transceiver tuning and loopbacks
  typedef struct packed {
    logic       rxEqualizerMode;
    logic [3:0] txDriverSwing;
    logic [4:0] txPreCursor;
    logic [4:0] txPostCursor;
    logic       pcsLoopbackEn;
    logic       macLoopbackEn;
    logic       macAddrSwapEn;
  } eth0Ctrl_t;

  // Network stack addresses
  typedef struct packed {
    logic [macWidth-1:0] macAddress;
    logic [ipWidth-1:0]  ipAddress;
    logic [ipWidth-1:0]  subNetMask;
    logic [ipWidth-1:0]  gatewayAddr;
  } ntsCfg_t;

  // Role echo/capture control plus outbound exchange word
  typedef struct packed {
    logic [1:0]              udpEchoCtrl;
    logic                    udpPostPktEn;
    logic                    udpCaptPktEn;
    logic [1:0]              tcpEchoCtrl;
    logic                    tcpPostPktEn;
    logic                    tcpCaptPktEn;
    logic [roleRegWidth-1:0] roleReg;
  } roleCtrl_t;

  // ----------------------------------------
  // Status inputs
  // ----------------------------------------
  typedef struct packed {
    logic                      mc0InitCalComplete;
    logic                      mc1InitCalComplete;
    logic                      eth0CoreReady;
    logic                      eth0QpllLock;
    logic [timestampWidth-1:0] timestamp;    // Build date, day:month:year at top
    logic [roleRegWidth-1:0]   roleReg;      // Inbound exchange word
  } shellStat_t;

endpackage

/* test/mmioRefModel.svh */
// MMIO reference model
// Shadow copies of the register file and page RAM, the expected read
// byte from the address map rules, and the LFSR for random stimulus

`ifndef mmioRefModelSvh
`define mmioRefModelSvh

localparam logic [7:0] emifIdExp = 8'h3C;
localparam logic [7:0] topIdExp  = 8'h81;

logic [7:0]  regShadow [128];              // Lower window, zero where nothing stored
logic [7:0]  ramShadow [pageCount*128];
logic [15:0] lfsrState;

// ----------------------------------------
// Fibonacci LFSR, taps 16 15 13 4
// ----------------------------------------
function automatic logic [31:0] randBits(int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++)
  begin
    lfsrState = {lfsrState[14:0],
                 lfsrState[15] ^ lfsrState[14] ^ lfsrState[12] ^ lfsrState[3]};
    val = {val[30:0], lfsrState[0]};   // One step per bit
  end
  return val;
endfunction

// ----------------------------------------
// Address map
// ----------------------------------------
function automatic logic writableOffset(logic [6:0] off);
  return (off >= 7'h11 && off <= 7'h13) || (off >= 7'h22 && off <= 7'h27) ||
         (off >= 7'h34 && off <= 7'h3F) || off == 7'h42 || off == 7'h43 ||
         (off >= 7'h70 && off <= 7'h74) || off == 7'h76 || off == 7'h7F;
endfunction

function automatic void resetShadow();
  for (int i = 0; i < 128; i++)
    regShadow[i] = 8'h00;
  {regShadow[7'h13], regShadow[7'h12], regShadow[7'h11]} = 24'h050541;
  {regShadow[7'h3B], regShadow[7'h3A], regShadow[7'h39], regShadow[7'h38]} = 32'h0000FFFF;
  {regShadow[7'h3F], regShadow[7'h3E], regShadow[7'h3D], regShadow[7'h3C]} = 32'hFE000C0A;
  {regShadow[7'h73], regShadow[7'h72], regShadow[7'h71], regShadow[7'h70]} = 32'hEFBEADDE;
endfunction

function automatic int ramIndex(logic [6:0] off);
  return (int'(regShadow[7'h7F]) % pageCount) * 128 + int'(off);   // Page then offset
endfunction

function automatic void shadowWrite(logic [7:0] addr, logic [7:0] data);
  if (addr[7])
    ramShadow[ramIndex(addr[6:0])] = data;
  else if (writableOffset(addr[6:0]))
    regShadow[addr[6:0]] = data;                                    // Others ignore writes
endfunction

function automatic logic [7:0] expectedByte(logic [7:0] addr, shellPkg::shellStat_t st);
  if (addr[7])
    return ramShadow[ramIndex(addr[6:0])];
  case (addr[6:0])
    7'h00: return emifIdExp;
    7'h01: return 8'h01;
    7'h02: return 8'h00;
    7'h03: return 8'h33;
    7'h04: return topIdExp;
    7'h05: return {2'b00, st.timestamp[22:17]};   // Year
    7'h06: return {4'h0, st.timestamp[26:23]};
    7'h07: return {3'b000, st.timestamp[31:27]};
    7'h10: return {4'h0, st.eth0QpllLock, st.eth0CoreReady,
                   st.mc1InitCalComplete, st.mc0InitCalComplete};
    7'h40: return st.roleReg[7:0];
    7'h41: return st.roleReg[15:8];
    default: return regShadow[addr[6:0]];
  endcase
endfunction

`endif

/* test/mmioClientTb.sv */
// MMIO client testbench
// Drives the chip-select bus on the falling edge, keeps a shadow model
// of the map and checks every read return and the control outputs

`timescale 1ns/1ns

module mmioClientTb;

  localparam int pageCount = 16;

  logic                 shlClk;
  logic                 rstN;
  mmioPkg::mmioReq_t    req;
  shellPkg::shellStat_t stat;
  mmioPkg::data_t       rdData;
  logic                 rdValid;
  shellPkg::eth0Ctrl_t  eth0Ctrl;
  shellPkg::ntsCfg_t    ntsCfg;
  shellPkg::roleCtrl_t  roleCtrl;

  logic [7:0] expQ [$];       // Pending reads, oldest first
  logic [7:0] addrQ [$];
  int         issueQ [$];     // Cycle of issue
  logic [7:0] expByte;
  logic [7:0] expAddr;
  int         issueCycle;
  int         cycleCount;
  int         valueErrors;
  int         otherErrors;
  string      testName;

  `include "mmioRefModel.svh"

  mmioClient #(.emifId(emifIdExp), .topId(topIdExp), .pageCount(pageCount)) mmioClient_i (
    .shlClk, .rstN, .req, .stat, .rdData, .rdValid, .eth0Ctrl, .ntsCfg, .roleCtrl
  );

  always #4 shlClk = ~shlClk;
  always @(posedge shlClk) cycleCount <= cycleCount + 1;

  // ----------------------------------------
  // Read return compare
  // ----------------------------------------
  always @(negedge shlClk)
  begin
    if (rstN && rdValid)
    begin
      assert (expQ.size() != 0)
      else
      begin
        otherErrors++;
        $display("Read data returned with no read pending in %s", testName);
      end
      if (expQ.size() != 0)
      begin
        expByte    = expQ.pop_front();
        expAddr    = addrQ.pop_front();
        issueCycle = issueQ.pop_front();
        assert (rdData === expByte)
        else
        begin
          valueErrors++;
          $display("FAIL %s @%02h expected %02h actual %02h", testName, expAddr, expByte, rdData);
        end
        assert (cycleCount - issueCycle == 1)       // Edge N to valid after N+1
        else
        begin
          otherErrors++;
          $display("Read of %02h in %s returned at the wrong cycle", expAddr, testName);
        end
      end
    end
  end

  // ----------------------------------------
  // Bus tasks
  // ----------------------------------------
  task automatic busAccess(input logic we, input logic [7:0] addr, input logic [7:0] data);
    @(negedge shlClk);
    req.cs = 1'b1;
    req.we = we;
    req.addr = addr;
    req.wrData = data;
    if (we)
      shadowWrite(addr, data);
    else
    begin
      expQ.push_back(expectedByte(addr, stat));
      addrQ.push_back(addr);
      issueQ.push_back(cycleCount);
    end
  endtask

  task automatic writeByte(input logic [7:0] addr, input logic [7:0] data);
    busAccess(1'b1, addr, data);
  endtask

  task automatic readByte(input logic [7:0] addr);
    busAccess(1'b0, addr, 8'h00);
  endtask

  // Idle the bus and wait for every pending read
  task automatic finishReads();
    int waited;
    waited = 0;
    @(negedge shlClk);
    req.cs = 1'b0;
    req.we = 1'b0;
    while (expQ.size() != 0 && waited < 50)
    begin
      @(negedge shlClk);
      waited++;
    end
    assert (expQ.size() == 0)
    else
    begin
      otherErrors++;
      $display("Timeout waiting for %0d read returns in %s", expQ.size(), testName);
      expQ.delete();
      addrQ.delete();
      issueQ.delete();
    end
  endtask

  task automatic checkValue(input string name, input logic [63:0] expVal,
                            input logic [63:0] actVal);
    assert (expVal === actVal)
    else
    begin
      valueErrors++;
      $display("FAIL %s expected %0h actual %0h", name, expVal, actVal);
    end
  endtask

  // Control outputs against the packing rules
  task automatic checkControl();
    logic [47:0] mac;
    logic [31:0] ip;
    logic [31:0] snm;
    logic [31:0] gtw;
    for (int b = 0; b < 6; b++)
      mac[8*b +: 8] = regShadow[7'h22 + b];     // Lowest offset is LSB
    for (int b = 0; b < 4; b++)
    begin
      ip[8*b +: 8]  = regShadow[7'h34 + b];
      snm[8*b +: 8] = regShadow[7'h38 + b];
      gtw[8*b +: 8] = regShadow[7'h3C + b];
    end
    checkValue("ntsCfg macAddress", mac, ntsCfg.macAddress);
    checkValue("ntsCfg ipAddress", ip, ntsCfg.ipAddress);
    checkValue("ntsCfg subNetMask", snm, ntsCfg.subNetMask);
    checkValue("ntsCfg gatewayAddr", gtw, ntsCfg.gatewayAddr);
    checkValue("eth0 rxEqualizerMode", regShadow[7'h11][0], eth0Ctrl.rxEqualizerMode);
    checkValue("eth0 txDriverSwing", regShadow[7'h11][7:4], eth0Ctrl.txDriverSwing);
    checkValue("eth0 txPreCursor", regShadow[7'h12][4:0], eth0Ctrl.txPreCursor);
    checkValue("eth0 txPostCursor", regShadow[7'h13][4:0], eth0Ctrl.txPostCursor);
    checkValue("eth0 loopback and swap", regShadow[7'h74][2:0],
               {eth0Ctrl.macAddrSwapEn, eth0Ctrl.macLoopbackEn, eth0Ctrl.pcsLoopbackEn});
    checkValue("role udp echo/post/capt", regShadow[7'h76][3:0],
               {roleCtrl.udpCaptPktEn, roleCtrl.udpPostPktEn, roleCtrl.udpEchoCtrl});
    checkValue("role tcp echo/post/capt", regShadow[7'h76][7:4],
               {roleCtrl.tcpCaptPktEn, roleCtrl.tcpPostPktEn, roleCtrl.tcpEchoCtrl});
    checkValue("role roleReg", {regShadow[7'h43], regShadow[7'h42]}, roleCtrl.roleReg);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial
  begin
    shlClk = 1'b0;
    rstN = 1'b0;
    req = '0;
    stat = '0;
    cycleCount = 0;
    valueErrors = 0;
    otherErrors = 0;
    lfsrState = 16'd41;
    resetShadow();
    repeat (4) @(posedge shlClk);
    @(negedge shlClk);
    rstN = 1'b1;

    testName = "reset values";
    for (int a = 0; a < 128; a++)
      readByte(8'(a));
    finishReads();
    checkControl();                             // Reset values on the outputs

    testName = "read write";
    for (int a = 0; a < 128; a++)
      if (writableOffset(7'(a)))
        writeByte(8'(a), 8'(randBits(8)));
    for (int a = 0; a < 128; a++)
      if (writableOffset(7'(a)))
        readByte(8'(a));
    finishReads();
    checkControl();

    testName = "read only";
    stat.timestamp = randBits(32);
    stat.roleReg = 16'(randBits(16));
    {stat.eth0QpllLock, stat.eth0CoreReady,
     stat.mc1InitCalComplete, stat.mc0InitCalComplete} = 4'(randBits(4));
    for (int a = 0; a < 128; a++)
      if (!writableOffset(7'(a)))
        readByte(8'(a));
    for (int a = 0; a < 128; a++)
      if (!writableOffset(7'(a)))
        writeByte(8'(a), 8'(randBits(8)));   // Must not stick
    for (int a = 0; a < 128; a++)
      if (!writableOffset(7'(a)))
        readByte(8'(a));
    finishReads();

    testName = "paged ram";
    for (int p = 0; p < 4; p++)
    begin
      writeByte(8'h7F, 8'(p * 5));              // Pages 0 5 10 15
      for (int k = 0; k < 16; k++)
        writeByte(8'h80 + 8'(k * 8), 8'(randBits(8)));
    end
    for (int p = 3; p >= 0; p--)
    begin
      writeByte(8'h7F, 8'(p * 5));
      for (int k = 0; k < 16; k++)
        readByte(8'h80 + 8'(k * 8));
    end
    finishReads();

    // Page 0 is selected again here
    testName = "back to back";
    for (int i = 0; i < 16; i++)
      readByte((i % 2 == 1) ? 8'h80 + 8'(i * 8) : 8'h70 + 8'(i % 4));
    finishReads();

    $display("Errors: %0d wrong values, %0d other", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
